/* verification/hdc_gen_chk.sv */
module hdc_gen_chk #(
    parameter int HV_W = 128
) (
    input logic            AXIS_ACLK,
    input logic            S_AXI_ARESETN,
    input logic            m_axis_tvalid,
    input logic            m_axis_tready,
    input logic [HV_W-1:0] m_axis_tdata,
    input logic            m_axis_tlast,
    input logic            hv_req,
    input logic            hv_ack,
    input logic            s_axi_bvalid,
    input logic            s_axi_rvalid
);

    timeunit 1ns;
    timeprecision 100ps;

    // ------------------------------
    // axi-stream master rules
    // ------------------------------
    // stalled beat must not move
    a_stream_hold: assert property (
        @(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        m_axis_tvalid && !m_axis_tready |=>
            m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast)
    ) else $error("stream beat changed or vanished while tready was low");

    // ------------------------------
    // four-phase req/ack
    // ------------------------------
    // req stays up until ack seen
    a_req_hold: assert property (
        @(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        hv_req && !hv_ack |=> hv_req
    ) else $error("hv_req dropped before hv_ack");

    // ack stays up while req still high
    a_ack_hold: assert property (
        @(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        hv_ack && hv_req |=> hv_ack
    ) else $error("hv_ack dropped while hv_req was high");

    // one response channel at a time
    a_resp_excl: assert property (
        @(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        !(s_axi_bvalid && s_axi_rvalid)
    ) else $error("bvalid and rvalid high in the same cycle");

endmodule

/* verification/tb_hdc_gen.sv */
module tb_hdc_gen;

    timeunit 1ns;
    timeprecision 100ps;

    import hdc_reg_pkg::*;
    import hdc_hv_pkg::*;

    localparam int HV_W           = 128;
    localparam int NUM_SLICES     = HV_W / WORD_W;
    localparam int BUS_TIMEOUT    = 50;
    // max gap between two accepted beats
    localparam int STREAM_TIMEOUT = 400;

    logic                   AXIS_ACLK;
    logic                   S_AXI_ARESETN;
    logic [AXIL_ADDR_W-1:0] s_axi_awaddr;
    logic                   s_axi_awvalid;
    logic                   s_axi_awready;
    logic [AXIL_DATA_W-1:0] s_axi_wdata;
    logic                   s_axi_wvalid;
    logic                   s_axi_wready;
    logic                   s_axi_bready;
    logic                   s_axi_bvalid;
    logic [1:0]             s_axi_bresp;
    logic [AXIL_ADDR_W-1:0] s_axi_araddr;
    logic                   s_axi_arvalid;
    logic                   s_axi_arready;
    logic                   s_axi_rready;
    logic                   s_axi_rvalid;
    logic [1:0]             s_axi_rresp;
    logic [AXIL_DATA_W-1:0] s_axi_rdata;
    logic                   m_axis_tready;
    logic                   m_axis_tvalid;
    logic [HV_W-1:0]        m_axis_tdata;
    logic                   m_axis_tlast;

    // galois lfsr state and model prng state
    logic [15:0]            lfsr_state;
    logic [WORD_W-1:0]      model_x;
    int                     value_errors;
    int                     timeout_errors;

    hdc_gen_top #(
        .HV_W (HV_W)
    ) i_dut (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bready  (s_axi_bready),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rready  (s_axi_rready),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rdata   (s_axi_rdata),
        .m_axis_tready (m_axis_tready),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tlast  (m_axis_tlast)
    );

    // protocol checker on the top, sees internal req/ack
    bind hdc_gen_top hdc_gen_chk #(
        .HV_W (HV_W)
    ) u_chk (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tlast  (m_axis_tlast),
        .hv_req        (hv_req),
        .hv_ack        (hv_ack),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_rvalid  (s_axi_rvalid)
    );

    // 4 ns period
    always #2 AXIS_ACLK = ~AXIS_ACLK;

    // ------------------------------
    // random source and model
    // ------------------------------
    // taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic random_bit();
        logic out;
        out        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        return out;
    endfunction

    function automatic logic [31:0] random_bits(input int nbits);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < nbits; i++) begin
            r = {r[30:0], random_bit()};
        end
        return r;
    endfunction

    // x ^= x<<13, x ^= x>>17, x ^= x<<5
    function automatic logic [WORD_W-1:0] xorshift_step(input logic [WORD_W-1:0] x);
        logic [WORD_W-1:0] y;
        y = x ^ (x << XS_SHIFT_A);
        y = y ^ (y >> XS_SHIFT_B);
        y = y ^ (y << XS_SHIFT_C);
        return y;
    endfunction

    // lowest slice gets the oldest word
    function automatic logic [HV_W-1:0] model_vector();
        logic [HV_W-1:0] v;
        int              k;
        v = '0;
        for (k = 0; k < NUM_SLICES; k++) begin
            v[k*WORD_W +: WORD_W] = model_x;
            model_x = xorshift_step(model_x);
        end
        return v;
    endfunction

    task automatic report_mismatch(input string test, input logic [HV_W-1:0] expected,
                                   input logic [HV_W-1:0] actual);
        $display("CHECK FAILED %s: expected %0h, actual %0h", test, expected, actual);
        value_errors++;
    endtask

    task automatic report_timeout(input string what);
        $display("timed out waiting for %s", what);
        timeout_errors++;
    endtask

    // ------------------------------
    // axi-lite master
    // ------------------------------
    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
        int cycles;
        bit addr_open;
        bit data_open;
        bit done;
        @(posedge AXIS_ACLK);
        s_axi_awaddr  <= addr;
        s_axi_awvalid <= 1'b1;
        s_axi_wdata   <= data;
        s_axi_wvalid  <= 1'b1;
        s_axi_bready  <= 1'b1;
        addr_open = 1'b1;
        data_open = 1'b1;
        cycles    = 0;
        while ((addr_open || data_open) && cycles < BUS_TIMEOUT) begin
            @(posedge AXIS_ACLK);
            cycles++;
            if (addr_open && s_axi_awready) begin
                addr_open = 1'b0;
                s_axi_awvalid <= 1'b0;
            end
            if (data_open && s_axi_wready) begin
                data_open = 1'b0;
                s_axi_wvalid <= 1'b0;
            end
        end
        if (addr_open || data_open) begin
            report_timeout("write address and data to be accepted");
            s_axi_awvalid <= 1'b0;
            s_axi_wvalid  <= 1'b0;
        end
        // response with bready already high
        done   = 1'b0;
        cycles = 0;
        while (!done && cycles < BUS_TIMEOUT) begin
            @(posedge AXIS_ACLK);
            cycles++;
            if (s_axi_bvalid) begin
                done = 1'b1;
                if (s_axi_bresp !== 2'b00) begin
                    report_mismatch("write bresp", 0, s_axi_bresp);
                end
            end
        end
        s_axi_bready <= 1'b0;
        if (!done) begin
            report_timeout("the write response");
        end
    endtask

    task automatic read_reg(input logic [31:0] addr, output logic [31:0] data);
        int cycles;
        bit done;
        @(posedge AXIS_ACLK);
        s_axi_araddr  <= addr;
        s_axi_arvalid <= 1'b1;
        s_axi_rready  <= 1'b1;
        done   = 1'b0;
        cycles = 0;
        while (!done && cycles < BUS_TIMEOUT) begin
            @(posedge AXIS_ACLK);
            cycles++;
            if (s_axi_arready) begin
                done = 1'b1;
            end
        end
        s_axi_arvalid <= 1'b0;
        if (!done) begin
            report_timeout("the read address to be accepted");
        end
        data   = '0;
        done   = 1'b0;
        cycles = 0;
        while (!done && cycles < BUS_TIMEOUT) begin
            @(posedge AXIS_ACLK);
            cycles++;
            if (s_axi_rvalid) begin
                done = 1'b1;
                data = s_axi_rdata;
                if (s_axi_rresp !== 2'b00) begin
                    report_mismatch("read rresp", 0, s_axi_rresp);
                end
            end
        end
        s_axi_rready <= 1'b0;
        if (!done) begin
            report_timeout("the read data");
        end
    endtask

    // ------------------------------
    // tests
    // ------------------------------
    task automatic check_registers();
        logic [31:0] data;
        logic [31:0] count_exp;
        logic [31:0] rd;
        data      = random_bits(32);
        count_exp = '0;
        count_exp[ITEM_AW-1:0] = data[ITEM_AW-1:0];
        write_reg(REG_COUNT_ADDR, data);
        read_reg(REG_COUNT_ADDR, rd);
        if (rd !== count_exp) begin
            report_mismatch("regs count readback", count_exp, rd);
        end
        // outside the register window, aliases of 0 and 4
        write_reg(32'h400, 32'h1);
        write_reg(32'h404, ~data);
        read_reg(32'h400, rd);
        if (rd !== 32'h0) begin
            report_mismatch("regs read 0x400", 0, rd);
        end
        read_reg(32'h404, rd);
        if (rd !== 32'h0) begin
            report_mismatch("regs read 0x404", 0, rd);
        end
        read_reg(REG_CTRL_ADDR, rd);
        if (rd !== 32'h0) begin
            report_mismatch("regs start bit after 0x400 write", 0, rd);
        end
        read_reg(REG_COUNT_ADDR, rd);
        if (rd !== count_exp) begin
            report_mismatch("regs count after 0x404 write", count_exp, rd);
        end
    endtask

    // vectors 0..n, tlast only on n
    task automatic collect_vectors(input string name, input int n, input bit throttle);
        logic [HV_W-1:0] expected;
        int              idx;
        int              cycles;
        idx    = 0;
        cycles = 0;
        m_axis_tready <= throttle ? random_bit() : 1'b1;
        while (idx <= n && cycles < STREAM_TIMEOUT) begin
            @(posedge AXIS_ACLK);
            cycles++;
            if (m_axis_tvalid && m_axis_tready) begin
                expected = model_vector();
                if (m_axis_tdata !== expected) begin
                    report_mismatch($sformatf("%s vector %0d tdata", name, idx),
                                    expected, m_axis_tdata);
                end
                if (m_axis_tlast !== (idx == n)) begin
                    report_mismatch($sformatf("%s vector %0d tlast", name, idx),
                                    (idx == n), m_axis_tlast);
                end
                idx++;
                cycles = 0;
            end
            m_axis_tready <= throttle ? random_bit() : 1'b1;
        end
        m_axis_tready <= 1'b1;
        if (idx <= n) begin
            report_timeout($sformatf("%s vector %0d of %0d", name, idx, n + 1));
        end
    endtask

    task automatic run_generation(input string name, input bit throttle);
        logic [31:0] rd;
        int          n;
        n = 1 + (random_bits(3) % 6);
        write_reg(REG_COUNT_ADDR, n);
        // every run starts from the seed
        model_x = XS_SEED;
        write_reg(REG_CTRL_ADDR, 32'h1);
        fork
            collect_vectors(name, n, throttle);
            begin
                read_reg(REG_CTRL_ADDR, rd);
                if (rd !== 32'h1) begin
                    report_mismatch({name, " start bit while running"}, 1, rd);
                end
                // second start, must be ignored
                write_reg(REG_CTRL_ADDR, 32'h1);
                // alias of the start bit, read while it is set
                read_reg(32'h400, rd);
                if (rd !== 32'h0) begin
                    report_mismatch({name, " read 0x400 while running"}, 0, rd);
                end
            end
        join
        read_reg(REG_CTRL_ADDR, rd);
        if (rd !== 32'h0) begin
            report_mismatch({name, " start bit after last vector"}, 0, rd);
        end
        // nothing more may follow tlast
        repeat (8) begin
            @(posedge AXIS_ACLK);
            if (m_axis_tvalid) begin
                $display("%s: a vector came out after the last one", name);
                value_errors++;
            end
        end
        m_axis_tready <= 1'b0;
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        AXIS_ACLK      = 1'b0;
        S_AXI_ARESETN  = 1'b0;
        s_axi_awaddr   = '0;
        s_axi_awvalid  = 1'b0;
        s_axi_wdata    = '0;
        s_axi_wvalid   = 1'b0;
        s_axi_bready   = 1'b0;
        s_axi_araddr   = '0;
        s_axi_arvalid  = 1'b0;
        s_axi_rready   = 1'b0;
        m_axis_tready  = 1'b0;
        lfsr_state     = 16'd39652;
        model_x        = XS_SEED;
        value_errors   = 0;
        timeout_errors = 0;
        repeat (3) @(posedge AXIS_ACLK);
        S_AXI_ARESETN <= 1'b1;

        check_registers();
        run_generation("gen_plain", 1'b0);
        run_generation("gen_throttled", 1'b1);
        run_generation("gen_restart", 1'b1);

        $display("errors: %0d wrong values, %0d timeouts", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
verilog/hdc_reg_pkg.sv
verilog/hdc_hv_pkg.sv
verilog/axil_regs.sv
verilog/xorshift32.sv
verilog/hv_assembler.sv
verilog/hv_stream_out.sv
verilog/hdc_gen_top.sv
verification/hdc_gen_chk.sv
verification/tb_hdc_gen.sv

/* verilog/axil_regs.sv */
module axil_regs (
    input  logic                                AXIS_ACLK,
    input  logic                                S_AXI_ARESETN,

    // write address and data channels
    input  logic [hdc_reg_pkg::AXIL_ADDR_W-1:0] s_axi_awaddr,
    input  logic                                s_axi_awvalid,
    output logic                                s_axi_awready,
    input  logic [hdc_reg_pkg::AXIL_DATA_W-1:0] s_axi_wdata,
    input  logic                                s_axi_wvalid,
    output logic                                s_axi_wready,

    // write response
    input  logic                                s_axi_bready,
    output logic                                s_axi_bvalid,
    output logic [1:0]                          s_axi_bresp,

    // read address and data
    input  logic [hdc_reg_pkg::AXIL_ADDR_W-1:0] s_axi_araddr,
    input  logic                                s_axi_arvalid,
    output logic                                s_axi_arready,
    input  logic                                s_axi_rready,
    output logic                                s_axi_rvalid,
    output logic [1:0]                          s_axi_rresp,
    output logic [hdc_reg_pkg::AXIL_DATA_W-1:0] s_axi_rdata,

    // generator control
    input  logic                                gen_done,
    output logic                                gen,
    output logic [hdc_hv_pkg::ITEM_AW-1:0]      item_count
);

    import hdc_reg_pkg::*;
    import hdc_hv_pkg::*;

    axil_state_t            state;

    // word-aligned addresses only
    logic [11:2]            write_addr;
    logic [11:2]            read_addr;
    logic [AXIL_DATA_W-1:0] write_data;

    // read accepted only when no write is pending in ini
    logic                   ar_take;
    logic                   reg_wr;
    logic                   reg_rd;

    // ------------------------------
    // channel handshakes
    // ------------------------------
    assign s_axi_awready = (state == ini) || (state == w);
    assign s_axi_wready  = (state == ini) || (state == aw);
    // a pending write holds off the read address
    assign s_axi_arready = (state == ini) && !s_axi_awvalid && !s_axi_wvalid;
    assign s_axi_bvalid  = (state == aww);
    assign s_axi_rvalid  = (state == ar2);
    // always OKAY
    assign s_axi_bresp   = 2'b00;
    assign s_axi_rresp   = 2'b00;

    assign ar_take = s_axi_arvalid && s_axi_arready;

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state <= ini;
        end else begin
            case (state)
                ini: begin
                    // write wins over read
                    if (s_axi_awvalid && s_axi_wvalid) begin
                        state <= aww;
                    end else if (s_axi_awvalid) begin
                        state <= aw;
                    end else if (s_axi_wvalid) begin
                        state <= w;
                    end else if (s_axi_arvalid) begin
                        state <= ar1;
                    end
                end
                // address seen, wait for data
                aw: if (s_axi_wvalid) state <= aww;
                // data seen, wait for address
                w: if (s_axi_awvalid) state <= aww;
                aww: if (s_axi_bready) state <= ini;
                // one cycle to look up the register
                ar1: state <= ar2;
                ar2: if (s_axi_rready) state <= ini;
                default: state <= ini;
            endcase
        end
    end

    // capture on each accepted beat
    always_ff @(posedge AXIS_ACLK) begin
        if (s_axi_awvalid && s_axi_awready) begin
            write_addr <= s_axi_awaddr[11:2];
        end
        if (s_axi_wvalid && s_axi_wready) begin
            write_data <= s_axi_wdata;
        end
        if (ar_take) begin
            read_addr <= s_axi_araddr[11:2];
        end
    end

    // ------------------------------
    // register file
    // ------------------------------
    // hits only inside the low 1 KiB window
    assign reg_wr = (state == aww) && (write_addr[11:10] == REG_SPACE_TOP);
    assign reg_rd = (state == ar1) && (read_addr[11:10] == REG_SPACE_TOP);

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            gen        <= 1'b0;
            item_count <= '0;
        end else begin
            // end of run takes priority over any start write
            if (gen_done) begin
                gen <= 1'b0;
            end else if (reg_wr && (write_addr[9:2] == REG_CTRL_ADDR[9:2])
                         && write_data[0] && !gen) begin
                gen <= 1'b1;
            end
            if (reg_wr && (write_addr[9:2] == REG_COUNT_ADDR[9:2])) begin
                item_count <= write_data[ITEM_AW-1:0];
            end
        end
    end

    // read data set in ar1, held through ar2
    always_ff @(posedge AXIS_ACLK) begin
        if (state == ar1) begin
            if (!reg_rd) begin
                s_axi_rdata <= '0;
            end else if (read_addr[9:2] == REG_CTRL_ADDR[9:2]) begin
                s_axi_rdata <= AXIL_DATA_W'(gen);
            end else if (read_addr[9:2] == REG_COUNT_ADDR[9:2]) begin
                s_axi_rdata <= AXIL_DATA_W'(item_count);
            end else begin
                s_axi_rdata <= '0;
            end
        end
    end

endmodule

/* verilog/hdc_gen_top.sv */
module hdc_gen_top #(
    parameter int HV_W = 128
) (
    input  logic                                AXIS_ACLK,
    input  logic                                S_AXI_ARESETN,

    // ------------------------------
    // axi-lite slave
    // ------------------------------
    input  logic [hdc_reg_pkg::AXIL_ADDR_W-1:0] s_axi_awaddr,
    input  logic                                s_axi_awvalid,
    output logic                                s_axi_awready,
    input  logic [hdc_reg_pkg::AXIL_DATA_W-1:0] s_axi_wdata,
    input  logic                                s_axi_wvalid,
    output logic                                s_axi_wready,
    input  logic                                s_axi_bready,
    output logic                                s_axi_bvalid,
    output logic [1:0]                          s_axi_bresp,
    input  logic [hdc_reg_pkg::AXIL_ADDR_W-1:0] s_axi_araddr,
    input  logic                                s_axi_arvalid,
    output logic                                s_axi_arready,
    input  logic                                s_axi_rready,
    output logic                                s_axi_rvalid,
    output logic [1:0]                          s_axi_rresp,
    output logic [hdc_reg_pkg::AXIL_DATA_W-1:0] s_axi_rdata,

    // ------------------------------
    // axi-stream master
    // ------------------------------
    input  logic                                m_axis_tready,
    output logic                                m_axis_tvalid,
    output logic [HV_W-1:0]                     m_axis_tdata,
    output logic                                m_axis_tlast
);

    import hdc_hv_pkg::*;

    // control between registers and datapath
    logic               gen;
    logic               gen_done;
    logic [ITEM_AW-1:0] item_count;

    // prng to assembler
    logic               step;
    logic [WORD_W-1:0]  rand_word;

    // assembler to streamer, four-phase
    logic               hv_req;
    logic               hv_ack;
    logic [HV_W-1:0]    hv_data;
    logic               hv_last;

    axil_regs u_regs (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bready  (s_axi_bready),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rready  (s_axi_rready),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rdata   (s_axi_rdata),
        .gen_done      (gen_done),
        .gen           (gen),
        .item_count    (item_count)
    );

    xorshift32 u_prng (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .gen           (gen),
        .step          (step),
        .rand_word     (rand_word)
    );

    hv_assembler #(
        .HV_W (HV_W)
    ) u_asm (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .gen           (gen),
        .item_count    (item_count),
        .rand_word     (rand_word),
        .hv_ack        (hv_ack),
        .step          (step),
        .hv_req        (hv_req),
        .hv_data       (hv_data),
        .hv_last       (hv_last)
    );

    hv_stream_out #(
        .HV_W (HV_W)
    ) u_out (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .hv_req        (hv_req),
        .hv_data       (hv_data),
        .hv_last       (hv_last),
        .hv_ack        (hv_ack),
        .m_axis_tready (m_axis_tready),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tlast  (m_axis_tlast),
        .gen_done      (gen_done)
    );

endmodule

/* verilog/hdc_hv_pkg.sv */
package hdc_hv_pkg;

    // ------------------------------
    // random word source
    // ------------------------------
    // one prng word per slice of a hypervector
    localparam int WORD_W = 32;

    // reseed value, 2463534242
    localparam logic [WORD_W-1:0] XS_SEED = 32'h92D6_8CA2;

    // shift amounts, applied left, right, left
    localparam int XS_SHIFT_A = 13;
    localparam int XS_SHIFT_B = 17;
    localparam int XS_SHIFT_C = 5;

    // ------------------------------
    // item numbering
    // ------------------------------
    // up to 1024 vectors per run
    localparam int ITEM_AW = 10;

endpackage

/* verilog/hdc_reg_pkg.sv */
package hdc_reg_pkg;

    // ------------------------------
    // bus widths
    // ------------------------------
    localparam int AXIL_ADDR_W = 32;
    localparam int AXIL_DATA_W = 32;

    // ------------------------------
    // register map
    // ------------------------------
    // bit 0 is the start bit
    localparam logic [AXIL_ADDR_W-1:0] REG_CTRL_ADDR  = 32'h0000_0000;
    // low ITEM_AW bits hold the item count
    localparam logic [AXIL_ADDR_W-1:0] REG_COUNT_ADDR = 32'h0000_0004;
    // addr[11:10] must match for a hit
    localparam logic [1:0]             REG_SPACE_TOP  = 2'b00;

    // axi-lite slave states, one-hot-ish codes
    typedef enum logic [3:0] {
        ini = 4'b0000,
        aw  = 4'b0001,
        w   = 4'b0010,
        aww = 4'b0011,
        ar1 = 4'b0100,
        ar2 = 4'b1000
    } axil_state_t;

endpackage

/* verilog/hv_assembler.sv */
module hv_assembler #(
    parameter int HV_W = 128
) (
    input  logic                           AXIS_ACLK,
    input  logic                           S_AXI_ARESETN,
    input  logic                           gen,
    input  logic [hdc_hv_pkg::ITEM_AW-1:0] item_count,
    input  logic [hdc_hv_pkg::WORD_W-1:0]  rand_word,
    input  logic                           hv_ack,
    output logic                           step,
    output logic                           hv_req,
    output logic [HV_W-1:0]                hv_data,
    output logic                           hv_last
);

    import hdc_hv_pkg::*;

    // HV_W is a whole number of prng words
    localparam int NUM_SLICES = HV_W / WORD_W;
    localparam int SLICE_AW   = (NUM_SLICES > 1) ? $clog2(NUM_SLICES) : 1;

    typedef enum logic [1:0] {
        s_fill,
        s_hold,
        s_req,
        s_done
    } asm_state_t;

    asm_state_t          state;
    logic [SLICE_AW-1:0] slice;
    logic [ITEM_AW-1:0]  item;
    logic                slice_end;

    // one word per cycle while filling
    assign step      = gen && (state == s_fill);
    assign slice_end = (slice == SLICE_AW'(NUM_SLICES - 1));

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !gen) begin
            state   <= s_fill;
            slice   <= '0;
            item    <= '0;
            hv_req  <= 1'b0;
            hv_last <= 1'b0;
        end else begin
            case (state)
                s_fill: begin
                    if (slice_end) begin
                        slice <= '0;
                        state <= s_hold;
                    end else begin
                        slice <= slice + 1'b1;
                    end
                end
                // previous ack must be gone before a new req
                s_hold: begin
                    if (!hv_ack) begin
                        hv_req  <= 1'b1;
                        hv_last <= (item == item_count);
                        state   <= s_req;
                    end
                end
                s_req: begin
                    if (hv_ack) begin
                        hv_req <= 1'b0;
                        if (hv_last) begin
                            state <= s_done;
                        end else begin
                            item  <= item + 1'b1;
                            state <= s_fill;
                        end
                    end
                end
                // parked until gen drops
                s_done: state <= s_done;
                default: state <= s_fill;
            endcase
        end
    end

    // slice k sits at bits WORD_W*k upward
    always_ff @(posedge AXIS_ACLK) begin
        if (step) begin
            hv_data[slice*WORD_W +: WORD_W] <= rand_word;
        end
    end

endmodule

/* verilog/hv_stream_out.sv */
module hv_stream_out #(
    parameter int HV_W = 128
) (
    input  logic            AXIS_ACLK,
    input  logic            S_AXI_ARESETN,

    // req/ack side from the assembler
    input  logic            hv_req,
    input  logic [HV_W-1:0] hv_data,
    input  logic            hv_last,
    output logic            hv_ack,

    // axi-stream master
    input  logic            m_axis_tready,
    output logic            m_axis_tvalid,
    output logic [HV_W-1:0] m_axis_tdata,
    output logic            m_axis_tlast,

    output logic            gen_done
);

    logic take;

    // ------------------------------
    // output slot
    // ------------------------------
    // new req, slot empty or draining this cycle
    assign take = hv_req && !hv_ack && (!m_axis_tvalid || m_axis_tready);

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            hv_ack        <= 1'b0;
            m_axis_tvalid <= 1'b0;
        end else begin
            // ack held until the assembler lets go of req
            if (take) begin
                hv_ack <= 1'b1;
            end else if (!hv_req) begin
                hv_ack <= 1'b0;
            end
            if (take) begin
                m_axis_tvalid <= 1'b1;
            end else if (m_axis_tready) begin
                m_axis_tvalid <= 1'b0;
            end
        end
    end

    // beat stays put under back-pressure
    always_ff @(posedge AXIS_ACLK) begin
        if (take) begin
            m_axis_tdata <= hv_data;
            m_axis_tlast <= hv_last;
        end
    end

    // last beat accepted ends the run
    assign gen_done = m_axis_tvalid && m_axis_tready && m_axis_tlast;

endmodule

/* verilog/xorshift32.sv */
module xorshift32 (
    input  logic                          AXIS_ACLK,
    input  logic                          S_AXI_ARESETN,
    input  logic                          gen,
    input  logic                          step,
    output logic [hdc_hv_pkg::WORD_W-1:0] rand_word
);

    import hdc_hv_pkg::*;

    logic [WORD_W-1:0] x;
    logic [WORD_W-1:0] x_next;

    // three xor-shift stages in sequence
    always_comb begin
        logic [WORD_W-1:0] t1;
        logic [WORD_W-1:0] t2;
        t1     = x ^ (x << XS_SHIFT_A);
        t2     = t1 ^ (t1 >> XS_SHIFT_B);
        x_next = t2 ^ (t2 << XS_SHIFT_C);
    end

    // reseed whenever idle so each run starts the same sequence
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !gen) begin
            x <= XS_SEED;
        end else if (step) begin
            x <= x_next;
        end
    end

    // word before the update, first one is the seed
    assign rand_word = x;

endmodule
